// ==== common/ahb_matrix_pkg.sv ====
// AHB decode fabric shared definitions

package ahb_matrix_pkg;

  // --------------------------------------------------------------------
  // Transfer and response codes
  // --------------------------------------------------------------------

  localparam logic [1:0] trans_idle   = 2'b00;  // No transfer
  localparam logic [1:0] trans_busy   = 2'b01;  // Manager inserting a gap
  localparam logic [1:0] trans_nonseq = 2'b10;  // Single or first beat
  localparam logic [1:0] trans_seq    = 2'b11;  // Later burst beat

  localparam logic [1:0] resp_okay  = 2'b00;
  localparam logic [1:0] resp_error = 2'b01;

  // --------------------------------------------------------------------
  // Output port indices
  // --------------------------------------------------------------------

  typedef enum logic [2:0]
  {
    port_mi0  = 3'b000,  // Memory port 0
    port_mi1  = 3'b001,  // Memory port 1
    port_mi2  = 3'b010,  // Memory port 2
    port_dflt = 3'b100   // Local default subordinate
  } port_sel_t;

  // --------------------------------------------------------------------
  // Address map on HADDR[31:10], bounds inclusive
  // --------------------------------------------------------------------

  // 0x00010000 to 0x000123FF
  localparam logic [21:0] mi0_lo = 22'h000040;
  localparam logic [21:0] mi0_hi = 22'h000048;

  // 0x00000000 to 0x000083FF
  localparam logic [21:0] mi1_lo = 22'h000000;
  localparam logic [21:0] mi1_hi = 22'h000020;

  // 0x10000000 to 0x100083FF
  localparam logic [21:0] mi2_lo = 22'h040000;
  localparam logic [21:0] mi2_hi = 22'h040020;

  // Word index is HADDR[13:2], larger regions alias
  localparam int sram_addr_bits = 12;

  // Data-phase wait states per memory port
  localparam int mi0_waits = 0;
  localparam int mi1_waits = 1;
  localparam int mi2_waits = 2;

endpackage

// ==== rtl/ahb_default_slave.sv ====
// AHB default subordinate

`timescale 1ns/100ps

module ahb_default_slave
(
  input  logic       HCLK,
  input  logic       HRESETn,
  input  logic       HSEL,       // Unmapped address selected
  input  logic       HREADY,     // Bus ready feedback
  input  logic [1:0] HTRANS,
  output logic       HREADYOUT,
  output logic [1:0] HRESP
);

  import ahb_matrix_pkg::*;

  // State bits {error flag, wait flag}
  //   00  idle, OKAY with no wait
  //   11  first ERROR cycle, HREADYOUT low
  //   10  second ERROR cycle, HREADYOUT high
  logic [1:0] resp_state;
  logic [1:0] resp_state_nxt;
  logic       idle_or_busy;   // No real transfer requested
  logic       err_start;      // Active transfer accepted here

  assign idle_or_busy = (HTRANS == trans_idle) || (HTRANS == trans_busy);
  assign err_start    = HSEL && HREADY && !idle_or_busy;

  // Wait flag shifts into error flag, so 11 steps to 10 then 00
  assign resp_state_nxt = err_start ? 2'b11 : {resp_state[0], 1'b0};

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      resp_state <= 2'b00;
    else
      resp_state <= resp_state_nxt;
  end

  assign HREADYOUT = ~resp_state[0];                          // Low in first ERROR cycle
  assign HRESP     = resp_state[1] ? resp_error : resp_okay;  // ERROR in both cycles

endmodule

// ==== rtl/ahb_sram_sub.sv ====
// AHB wait-state SRAM subordinate

`timescale 1ns/100ps

module ahb_sram_sub
#(
  parameter int WAIT_STATES = 0,                             // Data-phase wait cycles
  parameter int ADDR_BITS   = ahb_matrix_pkg::sram_addr_bits // Word index width
)
(
  input  logic        HCLK,
  input  logic        HRESETn,
  input  logic        HSEL,
  input  logic        HREADY,     // Bus ready feedback
  input  logic        HWRITE,
  input  logic [31:0] HADDR,
  input  logic [1:0]  HTRANS,
  input  logic [31:0] HWDATA,
  output logic        HREADYOUT,
  output logic [1:0]  HRESP,
  output logic [31:0] HRDATA
);

  import ahb_matrix_pkg::*;

  localparam int DEPTH    = 1 << ADDR_BITS;
  localparam int CNT_BITS = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  logic [31:0]          mem [DEPTH];  // Word storage
  logic                 accept;       // Active transfer taken this cycle
  logic                 data_phase;   // Transfer owns the data phase
  logic                 data_last;    // Final data-phase cycle
  logic [CNT_BITS-1:0]  wait_cnt;     // Remaining wait cycles
  logic [ADDR_BITS-1:0] idx_q;        // Captured word index
  logic                 wr_q;         // Captured write flag

  // --------------------------------------------------------------------
  // Address phase
  // --------------------------------------------------------------------

  assign accept = HSEL && HREADY &&
                  ((HTRANS == trans_nonseq) || (HTRANS == trans_seq));

  // Address and direction for the coming data phase
  always_ff @(posedge HCLK)
  begin
    if (accept)
    begin
      idx_q <= HADDR[ADDR_BITS+1:2];  // Word index, byte bits dropped
      wr_q  <= HWRITE;
    end
  end

  // --------------------------------------------------------------------
  // Data phase and wait counter
  // --------------------------------------------------------------------

  assign data_last = data_phase && (wait_cnt == '0);

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_phase <= 1'b0;
      wait_cnt   <= '0;
    end
    else if (accept)
    begin
      data_phase <= 1'b1;
      wait_cnt   <= CNT_BITS'(WAIT_STATES);  // Load full wait count
    end
    else if (data_last)
      data_phase <= 1'b0;                    // Done, counter already zero
    else if (data_phase)
      wait_cnt <= wait_cnt - CNT_BITS'(1);
  end

  // Memory cleared in reset, write lands on final cycle
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      for (int i = 0; i < DEPTH; i++)
        mem[i] <= '0;
    end
    else if (data_last && wr_q)
      mem[idx_q] <= HWDATA;
  end

  assign HREADYOUT = !data_phase || (wait_cnt == '0);  // Low while counting
  assign HRESP     = resp_okay;                        // Never errors
  assign HRDATA    = (data_last && !wr_q) ? mem[idx_q] : '0;

endmodule

// ==== ahb_bus_matrix/ahb_matrix_decoder.sv ====
// AHB matrix address decoder

`timescale 1ns/100ps

module ahb_matrix_decoder
(
  input  logic         HCLK,
  input  logic         HRESETn,
  input  logic         HREADYS,          // Bus ready feedback
  input  logic         sel_dec,          // Manager HSEL
  input  logic [31:10] decode_addr_dec,  // Upper HADDR bits
  input  logic [1:0]   trans_dec,        // Manager HTRANS

  input  logic         readyout_dec0,    // MI0 response
  input  logic [1:0]   resp_dec0,
  input  logic [31:0]  rdata_dec0,

  input  logic         readyout_dec1,    // MI1 response
  input  logic [1:0]   resp_dec1,
  input  logic [31:0]  rdata_dec1,

  input  logic         readyout_dec2,    // MI2 response
  input  logic [1:0]   resp_dec2,
  input  logic [31:0]  rdata_dec2,

  output logic         sel_dec0,         // Subordinate selects
  output logic         sel_dec1,
  output logic         sel_dec2,

  output logic         HREADYOUTS,       // Muxed response to manager
  output logic [1:0]   HRESPS,
  output logic [31:0]  HRDATAS
);

  import ahb_matrix_pkg::*;

  port_sel_t  addr_out_port;   // Port for current address phase
  port_sel_t  data_out_port;   // Port owning the data phase
  logic       hold_idle;       // IDLE keeps the data-phase port
  logic       sel_dft;         // Default subordinate select
  logic       readyout_dft;
  logic [1:0] resp_dft;

  // --------------------------------------------------------------------
  // Default subordinate for unmapped addresses
  // --------------------------------------------------------------------

  ahb_default_slave u_default_slave
  (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (sel_dft),
    .HREADY    (HREADYS),
    .HTRANS    (trans_dec),
    .HREADYOUT (readyout_dft),
    .HRESP     (resp_dft)
  );

  // --------------------------------------------------------------------
  // Address phase decode
  // --------------------------------------------------------------------

  assign hold_idle = (trans_dec == trans_idle);

  // Priority MI0, MI1, MI2, then default
  always_comb
  begin
    if (((decode_addr_dec >= mi0_lo) && (decode_addr_dec <= mi0_hi)) ||
        (hold_idle && (data_out_port == port_mi0)))
      addr_out_port = port_mi0;
    else if (((decode_addr_dec >= mi1_lo) && (decode_addr_dec <= mi1_hi)) ||
             (hold_idle && (data_out_port == port_mi1)))
      addr_out_port = port_mi1;
    else if (((decode_addr_dec >= mi2_lo) && (decode_addr_dec <= mi2_hi)) ||
             (hold_idle && (data_out_port == port_mi2)))
      addr_out_port = port_mi2;
    else
      addr_out_port = port_dflt;  // Unmapped
  end

  // Selects only while the manager drives HSEL
  always_comb
  begin
    sel_dec0 = 1'b0;
    sel_dec1 = 1'b0;
    sel_dec2 = 1'b0;
    sel_dft  = 1'b0;
    if (sel_dec)
    begin
      case (addr_out_port)
        port_mi0: sel_dec0 = 1'b1;
        port_mi1: sel_dec1 = 1'b1;
        port_mi2: sel_dec2 = 1'b1;
        default:  sel_dft  = 1'b1;
      endcase
    end
  end

  // --------------------------------------------------------------------
  // Data phase port and response mux
  // --------------------------------------------------------------------

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_out_port <= port_mi0;
    else if (HREADYS)
      data_out_port <= addr_out_port;  // Advance on completed phase
  end

  always_comb
  begin
    case (data_out_port)
      port_mi0:
      begin
        HREADYOUTS = readyout_dec0;
        HRESPS     = resp_dec0;
        HRDATAS    = rdata_dec0;
      end
      port_mi1:
      begin
        HREADYOUTS = readyout_dec1;
        HRESPS     = resp_dec1;
        HRDATAS    = rdata_dec1;
      end
      port_mi2:
      begin
        HREADYOUTS = readyout_dec2;
        HRESPS     = resp_dec2;
        HRDATAS    = rdata_dec2;
      end
      default:
      begin
        HREADYOUTS = readyout_dft;   // Default subordinate
        HRESPS     = resp_dft;
        HRDATAS    = '0;             // No read data
      end
    endcase
  end

endmodule

// ==== rtl/ahb_subsystem_top.sv ====
// AHB decode subsystem top level

`timescale 1ns/100ps

module ahb_subsystem_top
(
  input  logic        HCLK,
  input  logic        HRESETn,
  input  logic        HSEL,
  input  logic        HWRITE,
  input  logic [31:0] HADDR,
  input  logic [1:0]  HTRANS,
  input  logic [31:0] HWDATA,
  output logic        HREADYOUT,
  output logic [1:0]  HRESP,
  output logic [31:0] HRDATA
);

  import ahb_matrix_pkg::*;

  logic        hreadys;        // Ready fed back to all subordinates
  logic        sel_mi0;
  logic        sel_mi1;
  logic        sel_mi2;
  logic        readyout_mi0;
  logic        readyout_mi1;
  logic        readyout_mi2;
  logic [1:0]  resp_mi0;
  logic [1:0]  resp_mi1;
  logic [1:0]  resp_mi2;
  logic [31:0] rdata_mi0;
  logic [31:0] rdata_mi1;
  logic [31:0] rdata_mi2;

  // --------------------------------------------------------------------
  // Decoder
  // --------------------------------------------------------------------

  ahb_matrix_decoder u_matrix_decoder
  (
    .HCLK            (HCLK),
    .HRESETn         (HRESETn),
    .HREADYS         (hreadys),
    .sel_dec         (HSEL),
    .decode_addr_dec (HADDR[31:10]),  // Only upper bits decoded
    .trans_dec       (HTRANS),
    .readyout_dec0   (readyout_mi0),
    .resp_dec0       (resp_mi0),
    .rdata_dec0      (rdata_mi0),
    .readyout_dec1   (readyout_mi1),
    .resp_dec1       (resp_mi1),
    .rdata_dec1      (rdata_mi1),
    .readyout_dec2   (readyout_mi2),
    .resp_dec2       (resp_mi2),
    .rdata_dec2      (rdata_mi2),
    .sel_dec0        (sel_mi0),
    .sel_dec1        (sel_mi1),
    .sel_dec2        (sel_mi2),
    .HREADYOUTS      (hreadys),
    .HRESPS          (HRESP),
    .HRDATAS         (HRDATA)
  );

  assign HREADYOUT = hreadys;  // Same ready seen by manager and subordinates

  // --------------------------------------------------------------------
  // Memory subordinates
  // --------------------------------------------------------------------

  ahb_sram_sub #(.WAIT_STATES(mi0_waits), .ADDR_BITS(sram_addr_bits)) u_sram_mi0
  (
    .HCLK (HCLK), .HRESETn (HRESETn), .HSEL (sel_mi0), .HREADY (hreadys),
    .HWRITE (HWRITE), .HADDR (HADDR), .HTRANS (HTRANS), .HWDATA (HWDATA),
    .HREADYOUT (readyout_mi0), .HRESP (resp_mi0), .HRDATA (rdata_mi0)
  );

  ahb_sram_sub #(.WAIT_STATES(mi1_waits), .ADDR_BITS(sram_addr_bits)) u_sram_mi1
  (
    .HCLK (HCLK), .HRESETn (HRESETn), .HSEL (sel_mi1), .HREADY (hreadys),
    .HWRITE (HWRITE), .HADDR (HADDR), .HTRANS (HTRANS), .HWDATA (HWDATA),
    .HREADYOUT (readyout_mi1), .HRESP (resp_mi1), .HRDATA (rdata_mi1)
  );

  // Slowest port, two waits
  ahb_sram_sub #(.WAIT_STATES(mi2_waits), .ADDR_BITS(sram_addr_bits)) u_sram_mi2
  (
    .HCLK (HCLK), .HRESETn (HRESETn), .HSEL (sel_mi2), .HREADY (hreadys),
    .HWRITE (HWRITE), .HADDR (HADDR), .HTRANS (HTRANS), .HWDATA (HWDATA),
    .HREADYOUT (readyout_mi2), .HRESP (resp_mi2), .HRDATA (rdata_mi2)
  );

endmodule

// ==== verification/ahb_clk_gen.sv ====
// Testbench clock and reset

`timescale 1ns/100ps

module ahb_clk_gen
(
  output logic HCLK,
  output logic HRESETn
);

  // 4 ns period
  initial
  begin
    HCLK = 1'b0;
    forever #2 HCLK = ~HCLK;
  end

  // Low for three rising edges, released on an edge
  initial
  begin
    HRESETn = 1'b0;
    repeat (3) @(posedge HCLK);
    HRESETn <= 1'b1;
  end

endmodule

// ==== verification/ahb_decoder_checker.sv ====
// Decoder protocol assertions

`timescale 1ns/100ps

module ahb_decoder_checker
(
  input logic                     HCLK,
  input logic                     HRESETn,
  input logic                     HREADYS,
  input logic                     sel_dec0,
  input logic                     sel_dec1,
  input logic                     sel_dec2,
  input logic                     sel_dft,
  input logic                     HREADYOUTS,
  input logic [1:0]               HRESPS,
  input ahb_matrix_pkg::port_sel_t data_out_port
);

  import ahb_matrix_pkg::*;

  logic check_failed = 1'b0;  // Set by any failing assertion

  // At most one subordinate selected
  sel_onehot: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $onehot0({sel_dec0, sel_dec1, sel_dec2, sel_dft}))
    else
    begin
      check_failed = 1'b1;
      $error("More than one subordinate select is high");
    end

  // ERROR with low ready followed by ERROR with high ready
  err_two_cycle: assert property (@(posedge HCLK) disable iff (!HRESETn)
    ((HRESPS == resp_error) && !HREADYOUTS) |=> ((HRESPS == resp_error) && HREADYOUTS))
    else
    begin
      check_failed = 1'b1;
      $error("ERROR response not completed by a second ERROR cycle with ready high");
    end

  // Port owning data phase held during waits
  port_stable: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !HREADYS |=> $stable(data_out_port))
    else
    begin
      check_failed = 1'b1;
      $error("Data-phase port changed while ready was low");
    end

endmodule

// ==== verification/ahb_tb_top.sv ====
// AHB decode subsystem testbench

`timescale 1ns/100ps

module ahb_tb_top;

  import ahb_matrix_pkg::*;

  localparam int wait_limit = 20;   // Cycle timeout for any wait loop
  localparam int random_ops = 800;

  logic        HCLK;
  logic        HRESETn;
  logic        HSEL;
  logic        HWRITE;
  logic [31:0] HADDR;
  logic [1:0]  HTRANS;
  logic [31:0] HWDATA;
  logic        HREADYOUT;
  logic [1:0]  HRESP;
  logic [31:0] HRDATA;

  logic [31:0] model_mi0 [int];  // Reference memories by word index
  logic [31:0] model_mi1 [int];
  logic [31:0] model_mi2 [int];

  ahb_clk_gen u_clk_gen (.HCLK (HCLK), .HRESETn (HRESETn));

  ahb_subsystem_top DUT
  (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HWRITE    (HWRITE),
    .HADDR     (HADDR),
    .HTRANS    (HTRANS),
    .HWDATA    (HWDATA),
    .HREADYOUT (HREADYOUT),
    .HRESP     (HRESP),
    .HRDATA    (HRDATA)
  );

  bind ahb_matrix_decoder ahb_decoder_checker u_decoder_checker
  (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .HREADYS       (HREADYS),
    .sel_dec0      (sel_dec0),
    .sel_dec1      (sel_dec1),
    .sel_dec2      (sel_dec2),
    .sel_dft       (sel_dft),
    .HREADYOUTS    (HREADYOUTS),
    .HRESPS        (HRESPS),
    .data_out_port (data_out_port)
  );

  // --------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------

  function automatic port_sel_t port_of(input logic [31:0] addr);
    logic [21:0] upper;
    upper = addr[31:10];
    if ((upper >= mi0_lo) && (upper <= mi0_hi))
      return port_mi0;
    if ((upper >= mi1_lo) && (upper <= mi1_hi))
      return port_mi1;
    if ((upper >= mi2_lo) && (upper <= mi2_hi))
      return port_mi2;
    return port_dflt;
  endfunction

  function automatic int waits_of(input port_sel_t port);
    case (port)
      port_mi0: return mi0_waits;
      port_mi1: return mi1_waits;
      port_mi2: return mi2_waits;
      default:  return 1;  // Default subordinate has one low ERROR cycle
    endcase
  endfunction

  function automatic logic [31:0] region_base(input port_sel_t port);
    case (port)
      port_mi0: return {mi0_lo, 10'b0};
      port_mi1: return {mi1_lo, 10'b0};
      default:  return {mi2_lo, 10'b0};
    endcase
  endfunction

  function automatic int region_words(input port_sel_t port);
    case (port)
      port_mi0: return int'(mi0_hi - mi0_lo + 1) * 256;  // 256 words per KB
      port_mi1: return int'(mi1_hi - mi1_lo + 1) * 256;
      default:  return int'(mi2_hi - mi2_lo + 1) * 256;
    endcase
  endfunction

  function automatic int word_index(input logic [31:0] addr);
    return int'(addr[sram_addr_bits+1:2]);  // Aliases above 16 KB
  endfunction

  function automatic logic [31:0] model_read(input port_sel_t port, input logic [31:0] addr);
    int idx;
    idx = word_index(addr);
    case (port)
      port_mi0: return model_mi0.exists(idx) ? model_mi0[idx] : 32'h0;
      port_mi1: return model_mi1.exists(idx) ? model_mi1[idx] : 32'h0;
      port_mi2: return model_mi2.exists(idx) ? model_mi2[idx] : 32'h0;
      default:  return 32'h0;
    endcase
  endfunction

  task automatic model_write(input port_sel_t port, input logic [31:0] addr,
                             input logic [31:0] data);
    int idx;
    idx = word_index(addr);
    case (port)
      port_mi0: model_mi0[idx] = data;
      port_mi1: model_mi1[idx] = data;
      port_mi2: model_mi2[idx] = data;
      default:  ;  // Nothing stored for unmapped
    endcase
  endtask

  // --------------------------------------------------------------------
  // Manager side
  // --------------------------------------------------------------------

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Verification failed");
    $fatal(1, "Simulation stopped at first error");
  endtask

  // Bound decoder assertions stop the run at their first failure
  always @(negedge HCLK)
  begin
    assert (DUT.u_matrix_decoder.u_decoder_checker.check_failed !== 1'b1)
      else stop_on_error("A decoder protocol assertion failed");
  end

  // Address phase then data phase with outputs sampled at negedge
  task automatic run_transfer(input logic sel, input logic [1:0] trans,
                              input logic [31:0] addr, input logic write,
                              input logic [31:0] wdata, output int waits,
                              output logic [1:0] first_resp, output logic [1:0] last_resp,
                              output logic [31:0] rdata);
    int cycles;
    cycles = 0;
    waits  = 0;
    @(posedge HCLK);
    HSEL   <= sel;
    HADDR  <= addr;
    HTRANS <= trans;
    HWRITE <= write;
    @(negedge HCLK);
    while (!HREADYOUT)  // Address held until accepted
    begin
      cycles++;
      if (cycles > wait_limit)
        stop_on_error("Timed out waiting for HREADYOUT in the address phase");
      @(negedge HCLK);
    end
    @(posedge HCLK);
    HTRANS <= trans_idle;  // No pipelined follow-on transfer
    HWDATA <= wdata;
    @(negedge HCLK);
    first_resp = HRESP;
    while (!HREADYOUT)
    begin
      waits++;
      if (waits > wait_limit)
        stop_on_error("Timed out waiting for HREADYOUT in the data phase");
      @(negedge HCLK);
    end
    last_resp = HRESP;
    rdata     = HRDATA;
  endtask

  task automatic check_transfer(input logic sel, input logic [1:0] trans,
                                input logic [31:0] addr, input logic write,
                                input logic [31:0] wdata);
    port_sel_t   port;
    logic        active;
    int          waits;
    logic [1:0]  first_resp;
    logic [1:0]  last_resp;
    logic [31:0] rdata;
    logic [31:0] exp_data;
    port     = port_of(addr);
    active   = sel && ((trans == trans_nonseq) || (trans == trans_seq));
    exp_data = model_read(port, addr);  // Value before this transfer
    run_transfer(sel, trans, addr, write, wdata, waits, first_resp, last_resp, rdata);
    if (!active)
    begin
      assert ((waits == 0) && (last_resp == resp_okay))
        else stop_on_error($sformatf("[ERROR] %0t: no-op at %h took %0d waits, resp %b",
                                     $time, addr, waits, last_resp));
    end
    else if (port == port_dflt)
    begin
      assert ((waits == 1) && (first_resp == resp_error) && (last_resp == resp_error))
        else stop_on_error($sformatf("[ERROR] %0t: unmapped %h gave %0d waits, resp %b/%b",
                                     $time, addr, waits, first_resp, last_resp));
      assert (write || (rdata == 32'h0))
        else stop_on_error($sformatf("[ERROR] %0t: unmapped read %h returned %h",
                                     $time, addr, rdata));
    end
    else
    begin
      assert ((waits == waits_of(port)) && (first_resp == resp_okay) &&
              (last_resp == resp_okay))
        else stop_on_error($sformatf("[ERROR] %0t: %h gave %0d waits (exp %0d), resp %b/%b",
                                     $time, addr, waits, waits_of(port), first_resp, last_resp));
      if (write)
        model_write(port, addr, wdata);
      else
      begin
        assert (rdata == exp_data)
          else stop_on_error($sformatf("[ERROR] %0t: read %h got %h, exp %h",
                                       $time, addr, rdata, exp_data));
      end
    end
  endtask

  // --------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------

  initial
  begin
    int          cycles;
    int          kind;
    port_sel_t   port;
    logic [31:0] addr;
    logic [1:0]  trans;
    void'($urandom(32'hb0b7_bc12));
    HSEL   = 1'b0;
    HWRITE = 1'b0;
    HADDR  = 32'h0;
    HTRANS = trans_idle;
    HWDATA = 32'h0;
    cycles = 0;
    while (HRESETn !== 1'b1)
    begin
      cycles++;
      if (cycles > wait_limit)
        stop_on_error("Timed out waiting for reset release");
      @(negedge HCLK);
    end
    @(negedge HCLK);
    assert ((HREADYOUT === 1'b1) && (HRESP === resp_okay))
      else stop_on_error($sformatf("[ERROR] %0t: after reset ready %b resp %b",
                                   $time, HREADYOUT, HRESP));

    for (int n = 0; n < random_ops; n++)
    begin
      kind  = $urandom_range(0, 9);
      port  = port_sel_t'($urandom_range(0, 2));
      addr  = region_base(port) + ($urandom_range(0, region_words(port) - 1) << 2);
      trans = $urandom_range(0, 1) ? trans_seq : trans_nonseq;
      if (kind == 6)
      begin
        addr = $urandom & 32'hFFFF_FFFC;  // Nearly always unmapped
        if (port_of(addr) != port_dflt)
          addr = 32'h2000_0000 | addr[15:0];
      end
      if (kind <= 6)
        check_transfer(1'b1, trans, addr, 1'($urandom_range(0, 1)), $urandom);
      else if (kind == 7)
        check_transfer(1'b1, trans_idle, addr, 1'b1, $urandom);  // IDLE write attempt
      else
        check_transfer(1'b0, trans_nonseq, addr, 1'b1, $urandom); // HSEL low
    end

    // Full read sweep of every mapped word
    for (int p = 0; p < 3; p++)
    begin
      port = port_sel_t'(p);
      for (int w = 0; w < region_words(port); w++)
        check_transfer(1'b1, trans_nonseq, region_base(port) + (w << 2), 1'b0, 32'h0);
    end

    if (DUT.u_matrix_decoder.u_decoder_checker.check_failed === 1'b1)
      stop_on_error("A decoder protocol assertion failed near the end of the run");
    else
    begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

// ==== all.f ====
common/ahb_matrix_pkg.sv
rtl/ahb_default_slave.sv
rtl/ahb_sram_sub.sv
ahb_bus_matrix/ahb_matrix_decoder.sv
rtl/ahb_subsystem_top.sv
verification/ahb_clk_gen.sv
verification/ahb_decoder_checker.sv
verification/ahb_tb_top.sv
